// File: rtl/mips_macros.svh
// MIPS core constants

`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// architectural register count
`define MIPS_NUM_REGS 32

// word reads only, all byte lanes
`define MIPS_WB_SEL 4'hf

`endif

// File: rtl/mips_isa_pkg.sv
// MIPS instruction set types

package mips_isa_pkg;

	// data and address word
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;
	// raw I-type immediate
	typedef logic [15:0] imm_t;

	// major opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0a;

	// R-type function codes
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

endpackage

// File: rtl/mips_pipe_pkg.sv
// MIPS pipeline control types

package mips_pipe_pkg;

	// operations carried from decode to the ALU
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_NONE
	} alu_op_t;

	// instruction fetch FSM
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_BUS_WAIT,
		FETCH_HOLD
	} fetch_state_t;

endpackage

// File: rtl/instr_fetch.sv
// Instruction fetch unit
`timescale 1ns/100ps
`include "mips_macros.svh"

module instr_fetch (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output logic                 o_wb_we,
	output mips_isa_pkg::word_t  o_wb_adr,
	output logic [3:0]           o_wb_sel,
	input  logic                 i_wb_ack,
	input  mips_isa_pkg::word_t  i_wb_dat,
	output logic                 o_instr_valid,
	output mips_isa_pkg::word_t  o_instr,
	output mips_isa_pkg::word_t  o_next_pc,
	input  logic                 i_ready
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	fetch_state_t state;
	word_t        pc;

	// bus request lives for the whole wait state
	assign o_wb_cyc = (state == FETCH_BUS_WAIT);
	assign o_wb_stb = (state == FETCH_BUS_WAIT);
	assign o_wb_we  = 1'b0;
	assign o_wb_adr = pc;
	assign o_wb_sel = `MIPS_WB_SEL;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state         <= FETCH_IDLE;
			pc            <= `MIPS_RESET_PC;
			o_instr_valid <= 1'b0;
			o_instr       <= '0;
			o_next_pc     <= '0;
		end
		else
		begin
			case (state)
				FETCH_IDLE:
					state <= FETCH_BUS_WAIT;
				FETCH_BUS_WAIT:
				begin
					// capture the word and step the PC
					if (i_wb_ack)
					begin
						o_instr       <= i_wb_dat;
						o_next_pc     <= pc + 32'd4;
						pc            <= pc + 32'd4;
						o_instr_valid <= 1'b1;
						state         <= FETCH_HOLD;
					end
				end
				FETCH_HOLD:
				begin
					// next request only once decode has the word
					if (i_ready)
					begin
						o_instr_valid <= 1'b0;
						state         <= FETCH_BUS_WAIT;
					end
				end
				default:
					state <= FETCH_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/control.sv
// Main control decoder
`timescale 1ns/100ps

module control (
	input  mips_isa_pkg::opcode_t    i_opcode,
	input  mips_isa_pkg::funct_t     i_funct,
	output logic                     o_regdst,
	output logic                     o_alusrc,
	output logic                     o_regwrite,
	output mips_pipe_pkg::alu_op_t   o_aluop,
	output logic                     o_uses_rt
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	always_comb
	begin
		// unknown encodings fall through as no-ops
		o_regdst   = 1'b0;
		o_alusrc   = 1'b0;
		o_regwrite = 1'b0;
		o_aluop    = ALU_NONE;
		o_uses_rt  = 1'b0;
		case (i_opcode)
			OP_RTYPE:
			begin
				o_regdst   = 1'b1;
				o_regwrite = 1'b1;
				o_uses_rt  = 1'b1;
				case (i_funct)
					FN_ADD: o_aluop = ALU_ADD;
					FN_SUB: o_aluop = ALU_SUB;
					FN_AND: o_aluop = ALU_AND;
					FN_OR:  o_aluop = ALU_OR;
					FN_SLT: o_aluop = ALU_SLT;
					FN_SLL: o_aluop = ALU_SLL;
					default:
					begin
						o_regwrite = 1'b0;
						o_uses_rt  = 1'b0;
					end
				endcase
			end
			OP_ADDI:
			begin
				o_alusrc   = 1'b1;
				o_regwrite = 1'b1;
				o_aluop    = ALU_ADD;
			end
			OP_SLTI:
			begin
				o_alusrc   = 1'b1;
				o_regwrite = 1'b1;
				o_aluop    = ALU_SLT;
			end
			default:
				o_regwrite = 1'b0;
		endcase
	end

endmodule

// File: rtl/register_bank.sv
// Integer register file
`timescale 1ns/100ps
`include "mips_macros.svh"

module register_bank (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  mips_isa_pkg::reg_addr_t i_addr_rs,
	input  mips_isa_pkg::reg_addr_t i_addr_rt,
	output mips_isa_pkg::word_t     o_data_rs,
	output mips_isa_pkg::word_t     o_data_rt,
	input  logic                    i_wr_en,
	input  mips_isa_pkg::reg_addr_t i_addr_rd,
	input  mips_isa_pkg::word_t     i_data_rd
);
	import mips_isa_pkg::*;

	word_t regs [`MIPS_NUM_REGS];

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_wr_en && (i_addr_rd != '0))
		begin
			regs[i_addr_rd] <= i_data_rd;
		end
	end

	// r0 is hardwired, then same-cycle write bypass
	always_comb
	begin
		if (i_addr_rs == '0)
			o_data_rs = '0;
		else if (i_wr_en && (i_addr_rs == i_addr_rd))
			o_data_rs = i_data_rd;
		else
			o_data_rs = regs[i_addr_rs];

		if (i_addr_rt == '0)
			o_data_rt = '0;
		else if (i_wr_en && (i_addr_rt == i_addr_rd))
			o_data_rt = i_data_rd;
		else
			o_data_rt = regs[i_addr_rt];
	end

endmodule

// File: rtl/decode.sv
// Decode stage
`timescale 1ns/100ps

module decode (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_instr_valid,
	input  mips_isa_pkg::word_t     i_instr,
	input  mips_isa_pkg::word_t     i_next_pc,
	output logic                    o_ready,
	input  logic                    i_wr_en,
	input  mips_isa_pkg::reg_addr_t i_wr_addr,
	input  mips_isa_pkg::word_t     i_wr_data,
	output logic                    o_valid,
	output logic                    o_regdst,
	output logic                    o_alusrc,
	output logic                    o_regwrite,
	output mips_pipe_pkg::alu_op_t  o_aluop,
	output mips_isa_pkg::word_t     o_next_pc,
	output mips_isa_pkg::word_t     o_data_rs,
	output mips_isa_pkg::word_t     o_data_rt,
	output mips_isa_pkg::word_t     o_data_sign_ext,
	output mips_isa_pkg::reg_addr_t o_addr_rt,
	output mips_isa_pkg::reg_addr_t o_addr_rd,
	output mips_isa_pkg::shamt_t    o_shamt
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	reg_addr_t addr_rs;
	reg_addr_t addr_rt;
	imm_t      imm;
	word_t     sign_ext;
	word_t     data_rs;
	word_t     data_rt;
	logic      regdst;
	logic      alusrc;
	logic      regwrite;
	logic      uses_rt;
	alu_op_t   aluop;
	reg_addr_t held_dest;
	logic      hazard;
	logic      transfer;

	// ========================================================================
	// field split
	// ========================================================================
	assign addr_rs  = i_instr[25:21];
	assign addr_rt  = i_instr[20:16];
	assign imm      = i_instr[15:0];
	assign sign_ext = {{16{imm[15]}}, imm};

	// ========================================================================
	// hazard stall
	// ========================================================================
	// only the decode register can conflict, execute is bypassed in the bank
	assign held_dest = o_regdst ? o_addr_rd : o_addr_rt;
	assign hazard    = o_valid && o_regwrite && (held_dest != '0) &&
		((addr_rs == held_dest) || (uses_rt && (addr_rt == held_dest)));
	assign o_ready   = !hazard;
	assign transfer  = i_instr_valid && !hazard;

	control u_control (
		.i_opcode   (i_instr[31:26]),
		.i_funct    (i_instr[5:0]),
		.o_regdst   (regdst),
		.o_alusrc   (alusrc),
		.o_regwrite (regwrite),
		.o_aluop    (aluop),
		.o_uses_rt  (uses_rt)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_addr_rs (addr_rs),
		.i_addr_rt (addr_rt),
		.o_data_rs (data_rs),
		.o_data_rt (data_rt),
		.i_wr_en   (i_wr_en),
		.i_addr_rd (i_wr_addr),
		.i_data_rd (i_wr_data)
	);

	// ========================================================================
	// decode pipeline register
	// ========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid         <= 1'b0;
			o_regdst        <= 1'b0;
			o_alusrc        <= 1'b0;
			o_regwrite      <= 1'b0;
			o_aluop         <= ALU_NONE;
			o_next_pc       <= '0;
			o_data_rs       <= '0;
			o_data_rt       <= '0;
			o_data_sign_ext <= '0;
			o_addr_rt       <= '0;
			o_addr_rd       <= '0;
			o_shamt         <= '0;
		end
		else
		begin
			// a stall leaves a bubble behind
			o_valid <= transfer;
			if (transfer)
			begin
				o_regdst        <= regdst;
				o_alusrc        <= alusrc;
				o_regwrite      <= regwrite;
				o_aluop         <= aluop;
				o_next_pc       <= i_next_pc;
				o_data_rs       <= data_rs;
				o_data_rt       <= data_rt;
				o_data_sign_ext <= sign_ext;
				o_addr_rt       <= addr_rt;
				o_addr_rd       <= i_instr[15:11];
				o_shamt         <= i_instr[10:6];
			end
		end
	end

endmodule

// File: rtl/execute.sv
// Execute stage
`timescale 1ns/100ps

module execute (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_valid,
	input  logic                    i_regdst,
	input  logic                    i_alusrc,
	input  logic                    i_regwrite,
	input  mips_pipe_pkg::alu_op_t  i_aluop,
	input  mips_isa_pkg::word_t     i_next_pc,
	input  mips_isa_pkg::word_t     i_data_rs,
	input  mips_isa_pkg::word_t     i_data_rt,
	input  mips_isa_pkg::word_t     i_data_sign_ext,
	input  mips_isa_pkg::reg_addr_t i_addr_rt,
	input  mips_isa_pkg::reg_addr_t i_addr_rd,
	input  mips_isa_pkg::shamt_t    i_shamt,
	output logic                    o_wb_valid,
	output mips_isa_pkg::reg_addr_t o_wb_rd,
	output mips_isa_pkg::word_t     o_wb_data,
	output mips_isa_pkg::word_t     o_wb_pc
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	word_t     operand_b;
	word_t     result;
	reg_addr_t dest;

	assign operand_b = i_alusrc ? i_data_sign_ext : i_data_rt;
	assign dest      = i_regdst ? i_addr_rd : i_addr_rt;

	// ALU
	always_comb
	begin
		case (i_aluop)
			ALU_ADD: result = i_data_rs + operand_b;
			ALU_SUB: result = i_data_rs - operand_b;
			ALU_AND: result = i_data_rs & operand_b;
			ALU_OR:  result = i_data_rs | operand_b;
			ALU_SLT: result = {31'd0, $signed(i_data_rs) < $signed(operand_b)};
			ALU_SLL: result = i_data_rt << i_shamt;
			default: result = '0;
		endcase
	end

	// writeback register, r0 targets never report
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_wb_valid <= 1'b0;
			o_wb_rd    <= '0;
			o_wb_data  <= '0;
			o_wb_pc    <= '0;
		end
		else
		begin
			o_wb_valid <= i_valid && i_regwrite && (dest != '0);
			if (i_valid)
			begin
				o_wb_rd   <= dest;
				o_wb_data <= result;
				o_wb_pc   <= i_next_pc;
			end
		end
	end

endmodule

// File: rtl/mips_core.sv
// MIPS pipeline top level
`timescale 1ns/100ps

module mips_core (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output logic                    o_wb_we,
	output mips_isa_pkg::word_t     o_wb_adr,
	output logic [3:0]              o_wb_sel,
	input  logic                    i_wb_ack,
	input  mips_isa_pkg::word_t     i_wb_dat,
	output logic                    o_wb_valid,
	output mips_isa_pkg::reg_addr_t o_wb_rd,
	output mips_isa_pkg::word_t     o_wb_data,
	output mips_isa_pkg::word_t     o_wb_pc
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	// fetch to decode
	logic      instr_valid;
	word_t     instr;
	word_t     fetch_next_pc;
	logic      dec_ready;
	// decode to execute
	logic      dec_valid;
	logic      dec_regdst;
	logic      dec_alusrc;
	logic      dec_regwrite;
	alu_op_t   dec_aluop;
	word_t     dec_next_pc;
	word_t     dec_data_rs;
	word_t     dec_data_rt;
	word_t     dec_sign_ext;
	reg_addr_t dec_addr_rt;
	reg_addr_t dec_addr_rd;
	shamt_t    dec_shamt;

	instr_fetch u_fetch (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_we       (o_wb_we),
		.o_wb_adr      (o_wb_adr),
		.o_wb_sel      (o_wb_sel),
		.i_wb_ack      (i_wb_ack),
		.i_wb_dat      (i_wb_dat),
		.o_instr_valid (instr_valid),
		.o_instr       (instr),
		.o_next_pc     (fetch_next_pc),
		.i_ready       (dec_ready)
	);

	// writeback loops straight back into the register bank
	decode u_decode (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_instr_valid   (instr_valid),
		.i_instr         (instr),
		.i_next_pc       (fetch_next_pc),
		.o_ready         (dec_ready),
		.i_wr_en         (o_wb_valid),
		.i_wr_addr       (o_wb_rd),
		.i_wr_data       (o_wb_data),
		.o_valid         (dec_valid),
		.o_regdst        (dec_regdst),
		.o_alusrc        (dec_alusrc),
		.o_regwrite      (dec_regwrite),
		.o_aluop         (dec_aluop),
		.o_next_pc       (dec_next_pc),
		.o_data_rs       (dec_data_rs),
		.o_data_rt       (dec_data_rt),
		.o_data_sign_ext (dec_sign_ext),
		.o_addr_rt       (dec_addr_rt),
		.o_addr_rd       (dec_addr_rd),
		.o_shamt         (dec_shamt)
	);

	execute u_execute (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_valid         (dec_valid),
		.i_regdst        (dec_regdst),
		.i_alusrc        (dec_alusrc),
		.i_regwrite      (dec_regwrite),
		.i_aluop         (dec_aluop),
		.i_next_pc       (dec_next_pc),
		.i_data_rs       (dec_data_rs),
		.i_data_rt       (dec_data_rt),
		.i_data_sign_ext (dec_sign_ext),
		.i_addr_rt       (dec_addr_rt),
		.i_addr_rd       (dec_addr_rd),
		.i_shamt         (dec_shamt),
		.o_wb_valid      (o_wb_valid),
		.o_wb_rd         (o_wb_rd),
		.o_wb_data       (o_wb_data),
		.o_wb_pc         (o_wb_pc)
	);

endmodule

// File: test/core_checker.sv
// Writeback and bus checker
`timescale 1ns/100ps
`include "mips_macros.svh"

module core_checker (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_wb_cyc,
	input  logic                    i_wb_stb,
	input  logic                    i_wb_we,
	input  mips_isa_pkg::word_t     i_wb_adr,
	input  logic [3:0]              i_wb_sel,
	input  logic                    i_wb_ack,
	input  mips_isa_pkg::word_t     i_wb_dat,
	input  logic                    i_wb_valid,
	input  mips_isa_pkg::reg_addr_t i_wb_rd,
	input  mips_isa_pkg::word_t     i_wb_data,
	input  mips_isa_pkg::word_t     i_wb_pc,
	output int                      o_fetched,
	output int                      o_pending,
	output int                      o_data_errors,
	output int                      o_bus_errors
);
	import mips_isa_pkg::*;

	word_t     model_regs [`MIPS_NUM_REGS];
	word_t     model_pc;
	word_t     exp_pc [$];
	reg_addr_t exp_rd [$];
	word_t     exp_data [$];
	logic      req_waiting;
	word_t     req_adr;
	logic      ack_seen    = 1'b0;
	logic      check_idle  = 1'b0;
	reg_addr_t ref_rd;
	word_t     ref_val;
	int        fetched     = 0;
	int        pending     = 0;
	int        data_errors = 0;
	int        bus_errors  = 0;

	assign o_fetched     = fetched;
	assign o_pending     = pending;
	assign o_data_errors = data_errors;
	assign o_bus_errors  = bus_errors;

	// zero when the instruction writes no register
	function automatic reg_addr_t ref_dest(input word_t instr);
		reg_addr_t dest;
		dest = '0;
		case (instr[31:26])
			OP_RTYPE:
			begin
				case (instr[5:0])
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL:
						dest = instr[15:11];
					default:
						dest = '0;
				endcase
			end
			OP_ADDI, OP_SLTI:
				dest = instr[20:16];
			default:
				dest = '0;
		endcase
		return dest;
	endfunction

	// sequential ISA result for one instruction
	function automatic word_t ref_value(
		input word_t instr,
		input word_t rs_val,
		input word_t rt_val
	);
		word_t imm;
		word_t res;
		imm = {{16{instr[15]}}, instr[15:0]};
		res = '0;
		if (instr[31:26] == OP_ADDI)
			res = rs_val + imm;
		else if (instr[31:26] == OP_SLTI)
			res = ($signed(rs_val) < $signed(imm)) ? 32'd1 : 32'd0;
		else
		begin
			case (instr[5:0])
				FN_ADD: res = rs_val + rt_val;
				FN_SUB: res = rs_val - rt_val;
				FN_AND: res = rs_val & rt_val;
				FN_OR:  res = rs_val | rt_val;
				FN_SLT: res = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
				FN_SLL: res = rt_val << instr[10:6];
				default: res = '0;
			endcase
		end
		return res;
	endfunction

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED at %0t ns: %s expected %h actual %h",
				$time, name, expected, actual);
			data_errors++;
		end
	endtask

	task automatic bus_fault(input string what);
		$display("bus error at %0t ns: %s", $time, what);
		bus_errors++;
	endtask

	always @(posedge i_clk)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++)
				model_regs[i] = '0;
			model_pc    = `MIPS_RESET_PC;
			req_waiting = 1'b0;
			req_adr     = '0;
			ack_seen    = 1'b0;
			check_idle  = 1'b1;
			fetched     = 0;
			exp_pc.delete();
			exp_rd.delete();
			exp_data.delete();
			pending     = 0;
		end
		else
		begin
			// first cycle out of reset
			if (check_idle)
			begin
				if ((i_wb_cyc !== 1'b0) || (i_wb_stb !== 1'b0) || (i_wb_valid !== 1'b0))
					bus_fault("bus request or writeback active right after reset");
				check_idle = 1'b0;
			end

			// ================================================================
			// instruction bus protocol
			// ================================================================
			if (i_wb_cyc !== i_wb_stb)
				bus_fault("cyc and stb differ");
			if (i_wb_cyc && i_wb_we)
				bus_fault("write request on the instruction bus");
			if (i_wb_cyc && (i_wb_sel !== `MIPS_WB_SEL))
			begin
				$display("CHECK FAILED at %0t ns: o_wb_sel expected %h actual %h",
					$time, `MIPS_WB_SEL, i_wb_sel);
				bus_errors++;
			end
			if (ack_seen && i_wb_stb)
				bus_fault("request still raised in the cycle after ack");
			if (req_waiting)
			begin
				if (!i_wb_stb)
					bus_fault("request withdrawn before ack");
				else if (i_wb_adr !== req_adr)
				begin
					$display("CHECK FAILED at %0t ns: o_wb_adr expected %h actual %h",
						$time, req_adr, i_wb_adr);
					bus_errors++;
				end
			end
			req_waiting = i_wb_stb && !i_wb_ack;
			req_adr     = i_wb_adr;
			ack_seen    = i_wb_stb && i_wb_ack;

			// one fetch per ack in address order
			if (i_wb_stb && i_wb_ack)
			begin
				if (i_wb_adr !== model_pc)
				begin
					$display("CHECK FAILED at %0t ns: o_wb_adr expected %h actual %h",
						$time, model_pc, i_wb_adr);
					bus_errors++;
				end
				ref_rd  = ref_dest(i_wb_dat);
				ref_val = ref_value(i_wb_dat, model_regs[i_wb_dat[25:21]],
					model_regs[i_wb_dat[20:16]]);
				if (ref_rd != '0)
				begin
					model_regs[ref_rd] = ref_val;
					exp_pc.push_back(model_pc + 32'd4);
					exp_rd.push_back(ref_rd);
					exp_data.push_back(ref_val);
				end
				model_pc = model_pc + 32'd4;
				fetched++;
			end

			// ================================================================
			// writeback reports against the model
			// ================================================================
			if (i_wb_valid)
			begin
				if (exp_rd.size() == 0)
				begin
					$display("unexpected writeback report at %0t ns to r%0d", $time, i_wb_rd);
					data_errors++;
				end
				else
				begin
					compare_word("o_wb_pc", exp_pc.pop_front(), i_wb_pc);
					compare_word("o_wb_rd", {27'd0, exp_rd.pop_front()}, {27'd0, i_wb_rd});
					compare_word("o_wb_data", exp_data.pop_front(), i_wb_data);
				end
			end
			pending = exp_rd.size();
		end
	end

endmodule

// File: test/tb_mips_core.sv
// MIPS core testbench
`timescale 1ns/100ps

module tb_mips_core;
	import mips_isa_pkg::*;

	localparam int NUM_INSTR      = 200;
	localparam int CLK_PERIOD     = 100;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 100;

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	word_t       wb_adr;
	logic [3:0]  wb_sel;
	logic        wb_ack;
	word_t       wb_dat;
	logic        wb_valid;
	reg_addr_t   wb_rd;
	word_t       wb_data;
	word_t       wb_pc;
	int          fetched;
	int          pending;
	int          data_errors;
	int          bus_errors;

	word_t       prog [NUM_INSTR];
	logic [31:0] lfsr_state;
	logic [31:0] wait_left;
	logic        req_open;

	mips_core dut0 (
		.i_clk      (clk),
		.i_arst_n   (arst_n),
		.o_wb_cyc   (wb_cyc),
		.o_wb_stb   (wb_stb),
		.o_wb_we    (wb_we),
		.o_wb_adr   (wb_adr),
		.o_wb_sel   (wb_sel),
		.i_wb_ack   (wb_ack),
		.i_wb_dat   (wb_dat),
		.o_wb_valid (wb_valid),
		.o_wb_rd    (wb_rd),
		.o_wb_data  (wb_data),
		.o_wb_pc    (wb_pc)
	);

	core_checker u_checker (
		.i_clk         (clk),
		.i_arst_n      (arst_n),
		.i_wb_cyc      (wb_cyc),
		.i_wb_stb      (wb_stb),
		.i_wb_we       (wb_we),
		.i_wb_adr      (wb_adr),
		.i_wb_sel      (wb_sel),
		.i_wb_ack      (wb_ack),
		.i_wb_dat      (wb_dat),
		.i_wb_valid    (wb_valid),
		.i_wb_rd       (wb_rd),
		.i_wb_data     (wb_data),
		.i_wb_pc       (wb_pc),
		.o_fetched     (fetched),
		.o_pending     (pending),
		.o_data_errors (data_errors),
		.o_bus_errors  (bus_errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// random source and program
	// ========================================================================
	// right-shifting galois step
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic word_t enc_r(
		input logic [4:0] rs,
		input logic [4:0] rt,
		input logic [4:0] rd,
		input logic [4:0] shamt,
		input funct_t     fn
	);
		return {OP_RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t enc_i(
		input opcode_t     op,
		input logic [4:0]  rs,
		input logic [4:0]  rt,
		input logic [15:0] imm
	);
		return {op, rs, rt, imm};
	endfunction

	// small register pool r0..r3 keeps hazards frequent
	task automatic build_program();
		logic [31:0] kind;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] rd;
		logic [31:0] shamt;
		logic [31:0] imm;
		for (int n = 0; n < NUM_INSTR; n++)
		begin
			draw_bits(4, kind);
			draw_bits(2, rs);
			draw_bits(2, rt);
			draw_bits(2, rd);
			draw_bits(5, shamt);
			draw_bits(16, imm);
			case (kind)
				0: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_ADD);
				1: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_SUB);
				2: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_AND);
				3: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_OR);
				4: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, FN_SLT);
				5: prog[n] = enc_r(5'd0, rt[4:0], rd[4:0], shamt[4:0], FN_SLL);
				6: prog[n] = enc_i(OP_SLTI, rs[4:0], rt[4:0], imm[15:0]);
				// unsupported load opcode
				7: prog[n] = enc_i(6'h23, rs[4:0], rt[4:0], imm[15:0]);
				// unsupported addu funct
				8: prog[n] = enc_r(rs[4:0], rt[4:0], rd[4:0], 5'd0, 6'h21);
				default: prog[n] = enc_i(OP_ADDI, rs[4:0], rt[4:0], imm[15:0]);
			endcase
		end
	endtask

	// ========================================================================
	// wishbone memory model
	// ========================================================================
	// words past the program read as zero (sll to r0)
	function automatic word_t read_word(input word_t adr);
		word_t idx;
		idx = adr >> 2;
		if (idx < NUM_INSTR)
			return prog[idx];
		else
			return '0;
	endfunction

	always @(posedge clk)
	begin
		#1;
		if (wb_ack)
		begin
			wb_ack   = 1'b0;
			req_open = 1'b0;
		end
		else if (wb_cyc && wb_stb)
		begin
			if (!req_open)
			begin
				draw_bits(2, wait_left);
				req_open = 1'b1;
			end
			if (wait_left == 0)
			begin
				wb_ack = 1'b1;
				wb_dat = read_word(wb_adr);
			end
			else
				wait_left = wait_left - 1;
		end
	end

	// ========================================================================
	// run control
	// ========================================================================
	initial
	begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		wb_ack     = 1'b0;
		wb_dat     = '0;
		req_open   = 1'b0;
		wait_left  = '0;
		lfsr_state = 32'hecee25ec;
		build_program();
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		while (!(fetched >= NUM_INSTR && pending == 0))
			@(negedge clk);
		// trailing zero words must stay silent
		repeat (20) @(negedge clk);
		$display("errors: writeback %0d, bus %0d, unretired %0d",
			data_errors, bus_errors, pending);
		if (data_errors == 0 && bus_errors == 0 && pending == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("run timed out after %0d cycles, %0d instructions fetched", TIMEOUT_CYCLES,
			fetched);
		$display("errors: writeback %0d, bus %0d, unretired %0d",
			data_errors, bus_errors, pending);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/instr_fetch.sv
rtl/control.sv
rtl/register_bank.sv
rtl/decode.sv
rtl/execute.sv
rtl/mips_core.sv
test/core_checker.sv
test/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_isa_pkg.sv
      - rtl/mips_pipe_pkg.sv
      - rtl/instr_fetch.sv
      - rtl/control.sv
      - rtl/register_bank.sv
      - rtl/decode.sv
      - rtl/execute.sv
      - rtl/mips_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/core_checker.sv
      - test/tb_mips_core.sv
